//--- design/div_front.sv
`timescale 1ns/1ps

module div_front #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  accept,
    input  div_pkg::div_op_e      op,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    input  logic                  completed,
    input  logic                  flush,
    output div_pkg::div_flags_t   flags,
    output logic [data_width-1:0] abs_dividend,
    output logic [data_width-1:0] abs_divisor,
    output logic [data_width-1:0] dividend_q
);

    typedef logic [data_width-1:0] word_t;

    localparam word_t min_word = {1'b1, {(data_width-1){1'b0}}};

    word_t divisor_q;
    logic  signed_q;

    // Operands of the last divide that produced a response
    word_t last_dividend;
    word_t last_divisor;
    logic  last_signed;
    logic  last_valid;

    logic                is_signed;
    logic                dividend_neg;
    logic                divisor_neg;
    logic                div_zero;
    logic                overflow;
    logic                reuse;
    div_pkg::div_case_e  case_d;
    div_pkg::div_flags_t flags_d;

    ////////////////////
    // Classification
    ////////////////////

    assign is_signed    = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
    assign dividend_neg = is_signed && dividend[data_width-1];
    assign divisor_neg  = is_signed && divisor[data_width-1];

    assign div_zero = (divisor == '0);
    assign overflow = is_signed && (dividend == min_word) && (divisor == '1);

    // Quotient and remainder are both held, so op kind does not matter
    assign reuse = last_valid && (dividend == last_dividend) &&
                   (divisor == last_divisor) && (is_signed == last_signed);

    always_comb begin
        if (div_zero) begin
            case_d = div_pkg::CASE_DIV_ZERO;
        end else if (overflow) begin
            case_d = div_pkg::CASE_OVERFLOW;
        end else if (reuse) begin
            case_d = div_pkg::CASE_REUSE;
        end else begin
            case_d = div_pkg::CASE_NORMAL;
        end
    end

    always_comb begin
        flags_d.dcase    = case_d;
        flags_d.op       = op;
        // Zero divisor hands back raw all ones and the raw dividend
        flags_d.quot_neg = (dividend_neg ^ divisor_neg) && !div_zero;
        flags_d.rem_neg  = dividend_neg && !div_zero;
    end

    ////////////////////
    // Request registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (accept) begin
            flags <= flags_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dividend_q   <= dividend;
            divisor_q    <= divisor;
            signed_q     <= is_signed;
            abs_dividend <= dividend_neg ? (~dividend + 1'b1) : dividend;
            abs_divisor  <= divisor_neg ? (~divisor + 1'b1) : divisor;
        end
    end

    // Cancelled work leaves the held results stale
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_valid <= 1'b0;
        end else if (flush) begin
            last_valid <= 1'b0;
        end else if (completed) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (completed) begin
            last_dividend <= dividend_q;
            last_divisor  <= divisor_q;
            last_signed   <= signed_q;
        end
    end

endmodule

//--- design/div_iter.sv
`timescale 1ns/1ps

module div_iter #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  logic                  cancel,
    input  logic                  rsp_ready,
    input  div_pkg::div_flags_t   flags_in,
    input  logic [data_width-1:0] abs_dividend,
    input  logic [data_width-1:0] abs_divisor,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output logic                  accept,
    output logic                  done,
    output logic                  completed,
    output logic                  flush,
    output div_pkg::div_flags_t   flags_out,
    output logic [data_width-1:0] quotient,
    output logic [data_width-1:0] remainder
);

    localparam int step_w = $clog2(data_width);

    typedef logic [step_w-1:0]       step_t;
    typedef logic [2*data_width-1:0] wide_t;
    typedef logic [data_width:0]     trial_t;

    div_pkg::div_state_e state;
    div_pkg::div_state_e state_nxt;

    wide_t  part_rem;
    step_t  step_ptr;
    logic   steps_done;
    trial_t window;
    trial_t trial;
    logic   fits;
    logic   special;

    ////////////////////
    // Handshakes
    ////////////////////

    assign req_ready = (state == div_pkg::ST_IDLE);
    assign rsp_valid = (state == div_pkg::ST_DONE);
    assign accept    = req_valid && req_ready && !cancel;
    assign completed = rsp_valid && rsp_ready;
    assign flush     = cancel && ((state == div_pkg::ST_INIT) || (state == div_pkg::ST_BUSY));
    assign flags_out = flags_in;

    // Special cases and reuse bypass the engine
    assign special = (flags_in.dcase != div_pkg::CASE_NORMAL);

    // Result is ready for capture in the last cycle before ST_DONE
    assign done = !cancel &&
                  (((state == div_pkg::ST_INIT) && special) ||
                   ((state == div_pkg::ST_BUSY) && steps_done));

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            div_pkg::ST_IDLE: begin
                if (accept) begin
                    state_nxt = div_pkg::ST_INIT;
                end
            end
            div_pkg::ST_INIT: begin
                if (cancel) begin
                    state_nxt = div_pkg::ST_IDLE;
                end else if (special) begin
                    state_nxt = div_pkg::ST_DONE;
                end else begin
                    state_nxt = div_pkg::ST_BUSY;
                end
            end
            div_pkg::ST_BUSY: begin
                if (cancel) begin
                    state_nxt = div_pkg::ST_IDLE;
                end else if (steps_done) begin
                    state_nxt = div_pkg::ST_DONE;
                end
            end
            div_pkg::ST_DONE: begin
                if (completed) begin
                    state_nxt = div_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = div_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= div_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////
    // Shift-subtract engine
    ////////////////////

    // Trial subtract at the current bit position
    assign window = part_rem[step_ptr +: data_width+1];
    assign trial  = window - {1'b0, abs_divisor};
    assign fits   = !trial[data_width];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_ptr   <= '0;
            steps_done <= 1'b0;
        end else if (state == div_pkg::ST_INIT) begin
            step_ptr   <= step_t'(data_width - 1);
            steps_done <= 1'b0;
        end else if ((state == div_pkg::ST_BUSY) && !steps_done) begin
            step_ptr   <= step_ptr - 1'b1;
            steps_done <= (step_ptr == '0);
        end
    end

    always_ff @(posedge clk) begin
        if ((state == div_pkg::ST_INIT) && !special) begin
            part_rem <= {{data_width{1'b0}}, abs_dividend};
            quotient <= '0;
        end else if ((state == div_pkg::ST_BUSY) && !steps_done) begin
            quotient <= {quotient[data_width-2:0], fits};
            if (fits) begin
                part_rem[step_ptr +: data_width+1] <= trial;
            end
        end
    end

    assign remainder = part_rem[data_width-1:0];

    // Engine result rebuilds the dividend
    quot_rem_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state == div_pkg::ST_BUSY) && steps_done |->
            ((wide_t'(quotient) * wide_t'(abs_divisor) + wide_t'(remainder)) ==
             wide_t'(abs_dividend)));

    // Final partial remainder stays below the divisor
    rem_range_a: assert property (@(posedge clk) disable iff (!rst_n)
        (state == div_pkg::ST_BUSY) && steps_done |-> (part_rem < wide_t'(abs_divisor)));

    // Cancel must not drop a pending response
    rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid);

endmodule

//--- design/div_pkg.sv
package div_pkg;

    ////////////////////
    // Request encoding
    ////////////////////

    // Bit 0 set for the unsigned forms, bit 1 set for the remainder forms
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_e;

    // How the result of one request is formed
    typedef enum logic [1:0] {
        CASE_NORMAL   = 2'b00,
        CASE_DIV_ZERO = 2'b01,
        CASE_OVERFLOW = 2'b10,
        CASE_REUSE    = 2'b11
    } div_case_e;

    ////////////////////
    // Control
    ////////////////////

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_INIT = 2'b01,
        ST_BUSY = 2'b10,
        ST_DONE = 2'b11
    } div_state_e;

    // Per-request flags, captured on acceptance
    typedef struct packed {
        div_case_e dcase;
        div_op_e   op;
        // Negate the unsigned quotient
        logic      quot_neg;
        // Negate the unsigned remainder
        logic      rem_neg;
    } div_flags_t;

endpackage

//--- design/div_result.sv
`timescale 1ns/1ps

module div_result #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  done,
    input  div_pkg::div_flags_t   flags,
    input  logic [data_width-1:0] quotient,
    input  logic [data_width-1:0] remainder,
    input  logic [data_width-1:0] dividend_q,
    output logic [data_width-1:0] result
);

    typedef logic [data_width-1:0] word_t;

    localparam word_t min_word = {1'b1, {(data_width-1){1'b0}}};

    // Unsigned pair, kept for reuse by the next request
    word_t held_quot;
    word_t held_rem;

    word_t quot_fixed;
    word_t rem_fixed;
    logic  want_rem;

    ////////////////////
    // Held results
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_quot <= '0;
            held_rem  <= '0;
        end else if (done) begin
            case (flags.dcase)
                div_pkg::CASE_NORMAL: begin
                    held_quot <= quotient;
                    held_rem  <= remainder;
                end
                div_pkg::CASE_DIV_ZERO: begin
                    held_quot <= '1;
                    held_rem  <= dividend_q;
                end
                div_pkg::CASE_OVERFLOW: begin
                    held_quot <= min_word;
                    held_rem  <= '0;
                end
                default: begin
                    // Reuse keeps the pair from last time
                    held_quot <= held_quot;
                    held_rem  <= held_rem;
                end
            endcase
        end
    end

    ////////////////////
    // Sign fix and select
    ////////////////////

    assign quot_fixed = flags.quot_neg ? (~held_quot + 1'b1) : held_quot;
    assign rem_fixed  = flags.rem_neg ? (~held_rem + 1'b1) : held_rem;

    assign want_rem = (flags.op == div_pkg::OP_REM) || (flags.op == div_pkg::OP_REMU);
    assign result   = want_rem ? rem_fixed : quot_fixed;

endmodule

//--- design/div_unit.sv
`timescale 1ns/1ps

module div_unit #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cancel,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  div_pkg::div_op_e      op,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [data_width-1:0] result
);

    logic                  accept;
    logic                  done;
    logic                  completed;
    logic                  flush;
    div_pkg::div_flags_t   flags_front;
    div_pkg::div_flags_t   flags_iter;
    logic [data_width-1:0] abs_dividend;
    logic [data_width-1:0] abs_divisor;
    logic [data_width-1:0] dividend_q;
    logic [data_width-1:0] quotient;
    logic [data_width-1:0] remainder;

    // Request capture and case detection
    div_front #(
        .data_width(data_width)
    ) front0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .op          (op),
        .dividend    (dividend),
        .divisor     (divisor),
        .completed   (completed),
        .flush       (flush),
        .flags       (flags_front),
        .abs_dividend(abs_dividend),
        .abs_divisor (abs_divisor),
        .dividend_q  (dividend_q)
    );

    div_iter #(
        .data_width(data_width)
    ) iter0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .cancel      (cancel),
        .rsp_ready   (rsp_ready),
        .flags_in    (flags_front),
        .abs_dividend(abs_dividend),
        .abs_divisor (abs_divisor),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .accept      (accept),
        .done        (done),
        .completed   (completed),
        .flush       (flush),
        .flags_out   (flags_iter),
        .quotient    (quotient),
        .remainder   (remainder)
    );

    // Sign correction and output select
    div_result #(
        .data_width(data_width)
    ) result0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .flags     (flags_iter),
        .quotient  (quotient),
        .remainder (remainder),
        .dividend_q(dividend_q),
        .result    (result)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module div_unit_tb -f verilog.f -o div_sim

out=$(./obj_dir/div_sim)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

//--- verif/div_vectors.svh
`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// Columns: name, op, dividend, divisor, expected result, latency class
// Latency class lat_fast means at most 2 cycles, lat_full means 2 + data_width

task automatic load_table();
    // Unsigned forms
    add_vector("divu_basic",   div_pkg::OP_DIVU, 32'd100,       32'd7,         32'd14,        lat_full);
    add_vector("remu_basic",   div_pkg::OP_REMU, 32'd1000,      32'd7,         32'd6,         lat_full);
    add_vector("divu_small",   div_pkg::OP_DIVU, 32'd5,         32'd9,         32'd0,         lat_full);
    add_vector("remu_small",   div_pkg::OP_REMU, 32'd3,         32'd9,         32'd3,         lat_full);
    add_vector("divu_ones",    div_pkg::OP_DIVU, 32'hFFFF_FFFF, 32'd16,        32'h0FFF_FFFF, lat_full);
    add_vector("remu_ones",    div_pkg::OP_REMU, 32'hFFFF_FFFF, 32'd10,        32'd5,         lat_full);

    // Signed forms, every sign combination
    add_vector("div_pos_pos",  div_pkg::OP_DIV,  32'd47,        32'd5,         32'd9,         lat_full);
    add_vector("rem_pos_pos",  div_pkg::OP_REM,  32'd47,        32'd6,         32'd5,         lat_full);
    add_vector("div_neg_pos",  div_pkg::OP_DIV,  32'hFFFF_FFD1, 32'd5,         32'hFFFF_FFF7, lat_full);
    add_vector("rem_neg_pos",  div_pkg::OP_REM,  32'hFFFF_FFD1, 32'd6,         32'hFFFF_FFFB, lat_full);
    add_vector("div_pos_neg",  div_pkg::OP_DIV,  32'd47,        32'hFFFF_FFFB, 32'hFFFF_FFF7, lat_full);
    add_vector("rem_pos_neg",  div_pkg::OP_REM,  32'd47,        32'hFFFF_FFFA, 32'd5,         lat_full);
    add_vector("div_neg_neg",  div_pkg::OP_DIV,  32'hFFFF_FFD1, 32'hFFFF_FFFB, 32'd9,         lat_full);
    add_vector("rem_neg_neg",  div_pkg::OP_REM,  32'hFFFF_FFD1, 32'hFFFF_FFFA, 32'hFFFF_FFFB, lat_full);

    // Divide by zero
    add_vector("div_zero",     div_pkg::OP_DIV,  32'd1234,      32'd0,         32'hFFFF_FFFF, lat_fast);
    add_vector("divu_zero",    div_pkg::OP_DIVU, 32'h8000_0000, 32'd0,         32'hFFFF_FFFF, lat_fast);
    add_vector("rem_zero",     div_pkg::OP_REM,  32'hFFFF_FFD1, 32'd0,         32'hFFFF_FFD1, lat_fast);
    add_vector("remu_zero",    div_pkg::OP_REMU, 32'd1234,      32'd0,         32'd1234,      lat_fast);

    // Signed overflow
    add_vector("div_ovf",      div_pkg::OP_DIV,  32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, lat_fast);
    add_vector("rem_ovf",      div_pkg::OP_REM,  32'h8000_0000, 32'hFFFF_FFFF, 32'd0,         lat_fast);

    // Reuse after a DIV, then a change of signedness
    add_vector("div_reuse_src", div_pkg::OP_DIV,  32'hFFFF_FC18, 32'd7,        32'hFFFF_FF72, lat_full);
    add_vector("rem_reuse",     div_pkg::OP_REM,  32'hFFFF_FC18, 32'd7,        32'hFFFF_FFFA, lat_fast);
    add_vector("remu_after",    div_pkg::OP_REMU, 32'hFFFF_FC18, 32'd7,        32'd5,         lat_full);
endtask

`endif

//--- verif/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

    localparam int data_width     = 32;
    localparam int timeout_cycles = 100;
    localparam int quiet_cycles   = 40;
    localparam int random_count   = 40;

    typedef logic [data_width-1:0] word_t;

    localparam word_t min_word = {1'b1, {(data_width-1){1'b0}}};

    // Latency class of a vector
    localparam logic [1:0] lat_any  = 2'd0;
    localparam logic [1:0] lat_fast = 2'd1;
    localparam logic [1:0] lat_full = 2'd2;

    typedef struct packed {
        div_pkg::div_op_e op;
        word_t            dividend;
        word_t            divisor;
        word_t            expected;
        logic [1:0]       lat;
    } vec_t;

    logic             clk;
    logic             rst_n;
    logic             cancel;
    logic             req_valid;
    logic             req_ready;
    div_pkg::div_op_e req_op;
    word_t            req_dividend;
    word_t            req_divisor;
    logic             rsp_valid;
    logic             rsp_ready;
    word_t            result;

    string vec_name[$];
    vec_t  vec_data[$];
    int    tests;
    int    failed;
    int    errors;
    bit    hung;

    div_unit #(
        .data_width(data_width)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .cancel   (cancel),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .op       (req_op),
        .dividend (req_dividend),
        .divisor  (req_divisor),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic add_vector(input string name, input div_pkg::div_op_e op, input word_t a,
                              input word_t b, input word_t exp, input logic [1:0] lat);
        vec_t v;
        v.op       = op;
        v.dividend = a;
        v.divisor  = b;
        v.expected = exp;
        v.lat      = lat;
        vec_name.push_back(name);
        vec_data.push_back(v);
    endtask

    `include "div_vectors.svh"

    // RISC-V M-extension rule, including the two special cases
    function automatic word_t expected_result(div_pkg::div_op_e op, word_t a, word_t b);
        logic  is_signed;
        logic  want_rem;
        word_t q;
        word_t r;
        is_signed = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
        want_rem  = (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (is_signed && (a == min_word) && (b == '1)) begin
            q = a;
            r = '0;
        end else if (is_signed) begin
            q = word_t'($signed(a) / $signed(b));
            r = word_t'($signed(a) % $signed(b));
        end else begin
            q = a / b;
            r = a % b;
        end
        return want_rem ? r : q;
    endfunction

    // All driving happens 2 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%-16s ok", name);
        end else begin
            failed++;
            $display("%-16s failed", name);
        end
    endtask

    task automatic send_request(input string name, input div_pkg::div_op_e op, input word_t a,
                                input word_t b);
        int waited;
        waited = 0;
        while (!req_ready && (waited < timeout_cycles)) begin
            next_cycle();
            waited++;
        end
        if (!req_ready) begin
            $display("Error: %s timed out waiting for req_ready", name);
            errors++;
            hung = 1'b1;
        end else begin
            req_valid    = 1'b1;
            req_op       = op;
            req_dividend = a;
            req_divisor  = b;
            // Acceptance edge
            next_cycle();
            req_valid = 1'b0;
        end
    endtask

    task automatic run_op(input string name, input vec_t v, input int stall);
        int    err_before;
        int    lat;
        int    i;
        word_t got;
        err_before = errors;
        send_request(name, v.op, v.dividend, v.divisor);
        lat = 0;
        while (!hung && !rsp_valid && (lat < timeout_cycles)) begin
            next_cycle();
            lat++;
        end
        if (!hung && !rsp_valid) begin
            $display("Error: %s timed out waiting for rsp_valid", name);
            errors++;
            hung = 1'b1;
        end
        if (!hung) begin
            got = result;
            // Back-pressure, response must hold still
            for (i = 0; i < stall; i++) begin
                next_cycle();
                if (!rsp_valid) begin
                    $display("Error: %s dropped rsp_valid while rsp_ready was low", name);
                    errors++;
                end
                if (result != got) begin
                    $display("Mismatch %s: expected %h, actual %h", name, got, result);
                    errors++;
                end
                if (req_ready) begin
                    $display("Error: %s raised req_ready before the response completed", name);
                    errors++;
                end
            end
            rsp_ready = 1'b1;
            next_cycle();
            rsp_ready = 1'b0;
            if (rsp_valid) begin
                $display("Error: %s kept rsp_valid high after the response completed", name);
                errors++;
            end
            if (got != v.expected) begin
                $display("Mismatch %s: expected %h, actual %h", name, v.expected, got);
                errors++;
            end
            if ((v.lat == lat_fast) && (lat > 2)) begin
                $display("Error: %s took %0d cycles, expected at most 2", name, lat);
                errors++;
            end
            if ((v.lat == lat_full) && (lat != 2 + data_width)) begin
                $display("Error: %s took %0d cycles, expected %0d", name, lat, 2 + data_width);
                errors++;
            end
        end
        finish_test(name, err_before);
    endtask

    // Flush a divide in the middle of the engine run
    task automatic run_cancel(input string name, input vec_t v);
        int err_before;
        int i;
        err_before = errors;
        send_request(name, v.op, v.dividend, v.divisor);
        if (!hung) begin
            repeat (6) next_cycle();
            cancel = 1'b1;
            next_cycle();
            cancel = 1'b0;
            if (!req_ready) begin
                $display("Error: %s did not return req_ready after cancel", name);
                errors++;
            end
            for (i = 0; i < quiet_cycles; i++) begin
                if (rsp_valid) begin
                    $display("Error: %s produced a response after cancel", name);
                    errors++;
                end
                next_cycle();
            end
        end
        finish_test(name, err_before);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int         i;
        int         err_before;
        logic [1:0] op_bits;
        vec_t       v;
        void'($urandom(32'h25d4_5640));
        tests        = 0;
        failed       = 0;
        errors       = 0;
        hung         = 1'b0;
        rst_n        = 1'b0;
        cancel       = 1'b0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        req_op       = div_pkg::OP_DIV;
        req_dividend = '0;
        req_divisor  = '0;
        repeat (5) next_cycle();
        rst_n = 1'b1;

        err_before = errors;
        if (!req_ready || rsp_valid) begin
            $display("Error: handshake outputs wrong after reset");
            errors++;
        end
        finish_test("reset_state", err_before);

        load_table();
        for (i = 0; i < vec_name.size(); i++) begin
            if (hung) break;
            run_op(vec_name[i], vec_data[i], 0);
        end

        // Random operands, divisor scaled down to vary quotient length
        for (i = 0; i < random_count; i++) begin
            if (hung) break;
            op_bits    = 2'($urandom % 4);
            v.op       = div_pkg::div_op_e'(op_bits);
            v.dividend = $urandom;
            v.divisor  = $urandom >> ($urandom % data_width);
            v.expected = expected_result(v.op, v.dividend, v.divisor);
            v.lat      = lat_any;
            run_op($sformatf("rand_%0d", i), v, 0);
        end

        if (!hung) begin
            v.op       = div_pkg::OP_DIVU;
            v.dividend = 32'h1234_5678;
            v.divisor  = 32'h0000_0123;
            v.expected = expected_result(v.op, v.dividend, v.divisor);
            v.lat      = lat_full;
            run_cancel("cancel_busy", v);
        end
        // Same operands again must run the engine
        if (!hung) begin
            run_op("after_cancel", v, 0);
        end

        if (!hung) begin
            v.op       = div_pkg::OP_DIV;
            v.dividend = 32'h7FFF_FFF0;
            v.divisor  = 32'hFFFF_FFFD;
            v.expected = expected_result(v.op, v.dividend, v.divisor);
            v.lat      = lat_full;
            run_op("backpressure", v, 10);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
design/div_pkg.sv
design/div_front.sv
design/div_iter.sv
design/div_result.sv
design/div_unit.sv
verif/div_unit_tb.sv
